/* hdl/rv32i_types.sv */
`default_nettype none

package rv32i_types;

    // widths with a meaning of their own
    typedef logic [31:0]  addr_t;    // byte address
    typedef logic [31:0]  instr_t;   // one instruction word
    typedef logic [63:0]  beat_t;    // one burst memory beat
    typedef logic [255:0] line_t;    // one cache line, 8 words

    // cache address fields
    typedef logic [22:0]  tag_t;       // addr 31:9
    typedef logic [3:0]   set_idx_t;   // addr 8:5
    typedef logic [2:0]   word_off_t;  // addr 4:2

    localparam addr_t RESET_PC       = 32'h1eceb000;
    localparam int    BEATS_PER_LINE = 4;
    localparam int    WORDS_PER_LINE = 8;
    localparam int    NUM_SETS       = 16;
    localparam int    QUEUE_DEPTH    = 16;

    typedef enum logic {
        FETCH_IDLE,
        FETCH_WAIT
    } fetch_state_t;

    typedef enum logic [1:0] {
        CACHE_LOOKUP,
        CACHE_MISS,
        CACHE_FILL
    } cache_state_t;

    // pc and instruction move together from cache to queue
    typedef struct packed {
        addr_t  pc;
        instr_t instr;
    } fetch_pkt_t;

endpackage

`default_nettype wire

/* hdl/fetch_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               bmem_ready,
    input  logic               queue_full,
    input  logic               resp,
    output logic               req,
    output rv32i_types::addr_t req_addr
);
    import rv32i_types::*;

    fetch_state_t state;
    fetch_state_t state_next;
    addr_t        pc;
    logic         issue;

    // one request at a time, only with room in the queue and memory available
    assign issue    = (state == FETCH_IDLE) && bmem_ready && !queue_full;
    assign req_addr = pc;   // held steady for the whole wait

    always_comb begin
        state_next = state;
        case (state)
            FETCH_IDLE: begin
                if (issue) begin
                    state_next = FETCH_WAIT;
                end
            end
            FETCH_WAIT: begin
                if (resp) begin
                    state_next = FETCH_IDLE;
                end
            end
            default: begin
                state_next = FETCH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCH_IDLE;
            pc    <= RESET_PC;
            req   <= 1'b0;
        end else begin
            state <= state_next;
            req   <= issue;     // strobe lands in the first wait cycle

            // sequential fetch only, no redirects
            if (state == FETCH_WAIT && resp) begin
                pc <= pc + 32'd4;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/icache.sv */
`timescale 1ns/1ps
`default_nettype none

module icache (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req,
    input  rv32i_types::addr_t      req_addr,
    output logic                    resp,
    output rv32i_types::fetch_pkt_t resp_pkt,
    output rv32i_types::addr_t      bmem_addr,
    output logic                    bmem_read,
    input  rv32i_types::line_t      line,
    input  logic                    line_valid
);
    import rv32i_types::*;

    line_t                       data_arr [NUM_SETS];
    tag_t                        tag_arr  [NUM_SETS];
    logic [NUM_SETS-1:0]         valid_arr;

    cache_state_t                state;
    addr_t                       addr_q;     // request held across a miss

    set_idx_t                    req_idx;
    set_idx_t                    fill_idx;
    tag_t                        req_tag;
    word_off_t                   req_off;
    word_off_t                   fill_off;
    logic                        hit;
    instr_t [WORDS_PER_LINE-1:0] hit_words;
    instr_t [WORDS_PER_LINE-1:0] fill_words;

    assign req_idx  = req_addr[8:5];
    assign req_tag  = req_addr[31:9];
    assign req_off  = req_addr[4:2];
    assign fill_idx = addr_q[8:5];
    assign fill_off = addr_q[4:2];

    assign hit        = valid_arr[req_idx] && (tag_arr[req_idx] == req_tag);
    assign hit_words  = data_arr[req_idx];      // word 0 sits in bits 31:0
    assign fill_words = data_arr[fill_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= CACHE_LOOKUP;
            valid_arr <= '0;
            resp      <= 1'b0;
            bmem_read <= 1'b0;
        end else begin
            resp      <= 1'b0;
            bmem_read <= 1'b0;
            case (state)
                CACHE_LOOKUP: begin
                    if (req && hit) begin
                        resp <= 1'b1;
                    end else if (req) begin
                        bmem_read <= 1'b1;  // single pulse per miss
                        state     <= CACHE_MISS;
                    end
                end
                CACHE_MISS: begin
                    if (line_valid) begin
                        valid_arr[fill_idx] <= 1'b1;
                        state               <= CACHE_FILL;
                    end
                end
                CACHE_FILL: begin
                    resp  <= 1'b1;          // answer from the fresh line
                    state <= CACHE_LOOKUP;
                end
                default: begin
                    state <= CACHE_LOOKUP;
                end
            endcase
        end
    end

    // storage and response payload
    always_ff @(posedge clk) begin
        if (state == CACHE_LOOKUP && req) begin
            addr_q         <= req_addr;
            bmem_addr      <= {req_addr[31:5], 5'b0};
            resp_pkt.pc    <= req_addr;
            resp_pkt.instr <= hit_words[req_off];
        end
        if (state == CACHE_MISS && line_valid) begin
            data_arr[fill_idx] <= line;
            tag_arr[fill_idx]  <= addr_q[31:9];
        end
        if (state == CACHE_FILL) begin
            resp_pkt.instr <= fill_words[fill_off];
        end
    end

endmodule

`default_nettype wire

/* hdl/cacheline_adapter.sv */
`timescale 1ns/1ps
`default_nettype none

module cacheline_adapter (
    input  logic               clk,
    input  logic               rst,
    input  rv32i_types::beat_t bmem_rdata,
    input  logic               bmem_rvalid,
    output rv32i_types::line_t line,
    output logic               line_valid
);
    import rv32i_types::*;

    logic [$clog2(BEATS_PER_LINE)-1:0] beat_cnt;
    logic                              last_beat;

    // counter is all ones on the final beat of a burst
    assign last_beat = bmem_rvalid && (&beat_cnt);

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt   <= '0;
            line_valid <= 1'b0;
        end else begin
            line_valid <= last_beat;
            if (bmem_rvalid) begin
                beat_cnt <= beat_cnt + 1'b1;    // wraps back to 0 for next burst
            end
        end
    end

    // beats enter at the top and move down, so beat 0 ends up in 63:0
    always_ff @(posedge clk) begin
        if (bmem_rvalid) begin
            line <= {bmem_rdata, line[$bits(line_t)-1:$bits(beat_t)]};
        end
    end

endmodule

`default_nettype wire

/* hdl/instr_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_queue #(
    parameter int DEPTH = rv32i_types::QUEUE_DEPTH
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    push,
    input  rv32i_types::fetch_pkt_t push_pkt,
    input  logic                    pop,
    output rv32i_types::fetch_pkt_t head_pkt,
    output logic                    full,
    output logic                    empty
);
    import rv32i_types::*;

    typedef logic [$clog2(DEPTH)-1:0] ptr_t;

    fetch_pkt_t             mem [DEPTH];
    ptr_t                   wr_ptr;
    ptr_t                   rd_ptr;
    logic [$clog2(DEPTH):0] count;
    logic                   do_push;
    logic                   do_pop;

    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;    // pop on empty is dropped
    assign full     = count[$clog2(DEPTH)];  // msb only set at DEPTH
    assign empty    = (count == '0);
    assign head_pkt = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_pkt;
        end
    end

endmodule

`default_nettype wire

/* hdl/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  logic                    clk,
    input  logic                    rst,
    output rv32i_types::addr_t      bmem_addr,
    output logic                    bmem_read,
    input  logic                    bmem_ready,
    input  rv32i_types::beat_t      bmem_rdata,
    input  logic                    bmem_rvalid,
    input  logic                    instr_pop,
    output logic                    instr_valid,
    output rv32i_types::fetch_pkt_t instr_out
);
    import rv32i_types::*;

    addr_t      req_addr;
    logic       req;
    logic       resp;
    fetch_pkt_t resp_pkt;
    line_t      line;
    logic       line_valid;
    logic       queue_full;
    logic       queue_empty;

    assign instr_valid = !queue_empty;

    fetch_ctrl fetch_ctrl0 (
        .clk        (clk),
        .rst        (rst),
        .bmem_ready (bmem_ready),
        .queue_full (queue_full),
        .resp       (resp),
        .req        (req),
        .req_addr   (req_addr)
    );

    icache icache0 (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_addr   (req_addr),
        .resp       (resp),
        .resp_pkt   (resp_pkt),
        .bmem_addr  (bmem_addr),
        .bmem_read  (bmem_read),
        .line       (line),
        .line_valid (line_valid)
    );

    cacheline_adapter adapter0 (
        .clk         (clk),
        .rst         (rst),
        .bmem_rdata  (bmem_rdata),
        .bmem_rvalid (bmem_rvalid),
        .line        (line),
        .line_valid  (line_valid)
    );

    // every cache response is pushed straight in
    instr_queue #(.DEPTH(QUEUE_DEPTH)) queue0 (
        .clk      (clk),
        .rst      (rst),
        .push     (resp),
        .push_pkt (resp_pkt),
        .pop      (instr_pop),
        .head_pkt (instr_out),
        .full     (queue_full),
        .empty    (queue_empty)
    );

endmodule

`default_nettype wire

/* dv/fetch_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_assertions (
    input logic clk,
    input logic rst,
    input logic bmem_read,
    input logic req,
    input logic resp,
    input logic queue_full
);
    int   fail_count = 0;
    logic outstanding;      // a request is waiting for its response

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (req) begin
            outstanding <= 1'b1;
        end else if (resp) begin
            outstanding <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (rst) bmem_read |=> !bmem_read)
    else begin
        $error("bmem_read high for two cycles in a row");
        fail_count++;
    end

    // resp is the queue push
    assert property (@(posedge clk) disable iff (rst) resp |-> !queue_full)
    else begin
        $error("push into a full instruction queue");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (rst) req |-> !outstanding)
    else begin
        $error("req issued while a response is outstanding");
        fail_count++;
    end

endmodule

bind fetch_top fetch_assertions assertions0 (
    .clk        (clk),
    .rst        (rst),
    .bmem_read  (bmem_read),
    .req        (req),
    .resp       (resp),
    .queue_full (queue_full)
);

`default_nettype wire

/* dv/fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;
    import rv32i_types::*;

    // 12 bursts of at most ~40 cycles, the 300 and 100 cycle stalls, and a wide margin
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int NUM_INSTR      = 96;
    localparam int NUM_LINES      = NUM_INSTR / WORDS_PER_LINE;

    logic        clk;
    logic        rst;
    addr_t       bmem_addr;
    logic        bmem_read;
    logic        bmem_ready;
    beat_t       bmem_rdata;
    logic        bmem_rvalid;
    logic        instr_pop;
    logic        instr_valid;
    fetch_pkt_t  instr_out;

    fetch_pkt_t  popped_q [$];          // packets taken from the queue, oldest first
    int          errors         = 0;
    int          popped         = 0;
    int          checked        = 0;
    int          reads          = 0;
    int          reads_in_range = 0;
    int          cyc            = 0;
    int          stall_start    = 0;
    logic        stall_active   = 1'b0;
    addr_t       exp_line       = {RESET_PC[31:5], 5'b0};
    logic [31:0] pop_rng        = 32'h40d8_d6f2;

    fetch_top dut0 (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // memory content and expected instruction for any address
    function automatic instr_t ref_word(input addr_t addr);
        return addr ^ 32'hdead_beef;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // pop requests also go out while the queue is empty, the DUT must drop those
    task automatic pop_random(input int target, input int max_cycles);
        int n;
        n = 0;
        while (popped < target && n < max_cycles) begin
            @(negedge clk);
            pop_rng   = xorshift32(pop_rng);
            instr_pop = (pop_rng[1:0] != 2'b00);
            if (instr_pop && instr_valid) begin
                popped_q.push_back(instr_out);  // head as it leaves on the next edge
                popped++;
            end
            n++;
        end
        @(negedge clk);
        instr_pop = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d of %0d instructions checked",
                     cyc, checked, NUM_INSTR);
            $display(">>> FAIL");
            $finish;
        end
    end

    // burst memory, four beats per read with random gaps
    initial begin : memory_model
        logic [31:0] mem_rng;
        addr_t       base;
        mem_rng     = 32'h40d8_d6f2;
        bmem_rvalid = 1'b0;
        bmem_rdata  = '0;
        @(negedge clk);
        forever begin
            if (!rst && bmem_read) begin
                base = bmem_addr;
                for (int b = 0; b < BEATS_PER_LINE; b++) begin
                    mem_rng = xorshift32(mem_rng);
                    repeat (mem_rng[1:0]) @(negedge clk);   // 0 to 3 idle cycles
                    bmem_rvalid = 1'b1;
                    bmem_rdata  = {ref_word(base + 32'(8 * b + 4)), ref_word(base + 32'(8 * b))};
                    @(negedge clk);
                    bmem_rvalid = 1'b0;
                end
            end else begin
                @(negedge clk);
            end
        end
    end

    // every line read once, in order
    always @(negedge clk) begin
        if (!rst && bmem_read) begin
            check("bmem_addr", bmem_addr, exp_line);
            exp_line = exp_line + 32'd32;
            reads++;
            if (bmem_addr < RESET_PC + 32'(NUM_LINES * 32)) begin
                reads_in_range++;
            end
            if (stall_active && cyc > stall_start + 1) begin
                $display("bmem_read started at %0t while bmem_ready was held low", $time);
                errors++;
            end
        end
    end

    initial begin : compare
        fetch_pkt_t pkt;
        addr_t      exp_pc;
        exp_pc = RESET_PC;
        forever begin
            @(posedge clk);
            while (popped_q.size() > 0) begin
                pkt = popped_q.pop_front();
                check("instr_out.pc", pkt.pc, exp_pc);
                check("instr_out.instr", pkt.instr, ref_word(exp_pc));
                exp_pc = exp_pc + 32'd4;
                checked++;
            end
        end
    end

    initial begin : stimulus
        logic seen_valid;
        int   reads_mid;
        rst        = 1'b1;
        bmem_ready = 1'b1;
        instr_pop  = 1'b0;
        seen_valid = 1'b0;
        reads_mid  = 0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        check("bmem_read", 32'(bmem_read), 32'd0);
        check("instr_valid", 32'(instr_valid), 32'd0);

        pop_random(32, TIMEOUT_CYCLES);

        for (int i = 0; i < 300; i++) begin     // queue fills up, then fetch must stop
            @(negedge clk);
            if (instr_valid) begin
                seen_valid = 1'b1;
            end else if (seen_valid) begin
                $display("instr_valid dropped at %0t while no pops were issued", $time);
                errors++;
            end
            if (i == 200) begin
                reads_mid = reads;
            end
        end
        check("instr_valid", 32'(instr_valid), 32'd1);
        check("bmem_read count", reads, reads_mid);
        check("bmem_read count", reads,
              (popped + QUEUE_DEPTH + WORDS_PER_LINE - 1) / WORDS_PER_LINE);

        pop_random(56, TIMEOUT_CYCLES);

        stall_start  = cyc;
        stall_active = 1'b1;
        bmem_ready   = 1'b0;
        pop_random(NUM_INSTR, 100);             // queue drains meanwhile
        bmem_ready   = 1'b1;
        stall_active = 1'b0;

        pop_random(NUM_INSTR, TIMEOUT_CYCLES);
        while (checked < NUM_INSTR) begin
            @(posedge clk);
        end
        check("bmem_read count", reads_in_range, NUM_LINES);

        $display("%0d instructions checked, %0d errors, %0d assertion failures",
                 checked, errors, dut0.assertions0.fail_count);
        if (errors == 0 && dut0.assertions0.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
hdl/rv32i_types.sv
hdl/fetch_ctrl.sv
hdl/icache.sv
hdl/cacheline_adapter.sv
hdl/instr_queue.sv
hdl/fetch_top.sv
dv/fetch_assertions.sv
dv/fetch_tb.sv

/* Makefile */
SIM   = verilator
FLAGS = --binary --timing --assert
TOP   = fetch_tb
FLIST = compile.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
